// ==== Makefile ====
# Verilator flow for the router output port

VERILATOR ?= verilator
TOP       ?= routerPortTb
FLIST     ?= routerPort.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing -Wall
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(wildcard src/*.sv src/*.svh test/*.sv test/*.svh)
	$(VERILATOR) --binary $(VFLAGS) -j 0 -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== routerPort.f ====
+incdir+src
+incdir+test
src/nocPkg.sv
src/inputBuffer.sv
src/holdTimer.sv
src/switchArbiter.sv
src/outputStage.sv
src/routerPort.sv
test/routerPortTb.sv

// ==== src/holdTimer.sv ====
`default_nettype none

module holdTimer
  import nocPkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     load,
  input  wire holdLen_t loadLen,
  input  wire logic     run,
  input  wire logic     restart,
  output logic          expired
);

  holdLen_t limit;
  holdLen_t count;
  holdLen_t effLimit;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (load)
        limit <= loadLen;  // kept until the next header
      if (restart)
        count <= '0;
      else if (run)
        count <= count + 1'b1;
    end
  end

  assign effLimit = (limit == '0) ? holdLen_t'(1) : limit;

  // a new header may shrink the limit below the running count
  assign expired = (count >= effLimit);

endmodule

`default_nettype wire

// ==== src/inputBuffer.sv ====
`default_nettype none

`include "router_config.svh"

module inputBuffer
  import nocPkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire flit_t inFlit,
  input  wire logic  inValid,
  output logic       inReady,
  input  wire logic  pop,
  output logic       req,
  output flit_t      head
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  flit_t mem [`FIFO_DEPTH];

  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] nextCount;
  logic             doWrite;
  logic             doPop;

  assign doWrite = inValid && inReady;
  assign doPop   = pop && req;  // ignore pops on an empty buffer

  always_comb
  begin
    nextCount = count;
    if (doWrite && !doPop)
      nextCount = count + 1'b1;
    else if (doPop && !doWrite)
      nextCount = count - 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      inReady <= 1'b0;
    end
    else
    begin
      count   <= nextCount;
      inReady <= (nextCount != CNT_W'(`FIFO_DEPTH));  // registered full flag
      if (doWrite)
      begin
        if (wrPtr == PTR_W'(`FIFO_DEPTH - 1))
          wrPtr <= '0;
        else
          wrPtr <= wrPtr + 1'b1;
      end
      if (doPop)
      begin
        if (rdPtr == PTR_W'(`FIFO_DEPTH - 1))
          rdPtr <= '0;
        else
          rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= inFlit;
  end

  assign req  = (count != '0);
  assign head = mem[rdPtr];

endmodule

`default_nettype wire

// ==== src/nocPkg.sv ====
`default_nettype none

`include "router_config.svh"

package nocPkg;

  typedef logic [`FLIT_ID_W-1:0] flitId_t;
  typedef logic [`FLIT_DATA_W-1:0] payload_t;
  typedef logic [`LEN_W-1:0] holdLen_t;
  typedef logic [`PORT_ID_W-1:0] portId_t;

  localparam flitId_t FLIT_HEAD = 3'd1;
  localparam flitId_t FLIT_BODY = 3'd2;
  localparam flitId_t FLIT_TAIL = 3'd3;

  localparam portId_t PORT_L = 3'd0;
  localparam portId_t PORT_N = 3'd1;
  localparam portId_t PORT_E = 3'd2;
  localparam portId_t PORT_W = 3'd3;
  localparam portId_t PORT_S = 3'd4;

  typedef struct packed {
    flitId_t  flitId;
    payload_t payload;  // header: length in [LEN_W-1:0]
  } flit_t;

  // GRANT_x encodes port x plus one
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    GRANT_L = 3'd1,
    GRANT_N = 3'd2,
    GRANT_E = 3'd3,
    GRANT_W = 3'd4,
    GRANT_S = 3'd5
  } arbState_e;

endpackage

`default_nettype wire

// ==== src/outputStage.sv ====
`default_nettype none

`include "router_config.svh"

module outputStage
  import nocPkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire flit_t [`NUM_PORTS-1:0] heads,
  input  wire logic                   grantValid,
  input  wire portId_t                grantPort,
  output logic                        take,
  output flit_t                       outFlit,
  output portId_t                     outSrc,
  output logic                        outValid,
  input  wire logic                   outReady
);

  logic  canAccept;
  flit_t selFlit;

  // empty, or the current flit leaves this cycle
  assign canAccept = !outValid || outReady;
  assign take      = grantValid && canAccept;
  assign selFlit   = heads[grantPort];

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (take)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  // held steady while the link stalls
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      outFlit <= selFlit;
      outSrc  <= grantPort;
    end
  end

endmodule

`default_nettype wire

// ==== src/routerPort.sv ====
`default_nettype none

`include "router_config.svh"

module routerPort
  import nocPkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire flit_t [`NUM_PORTS-1:0] inFlit,
  input  wire logic [`NUM_PORTS-1:0]  inValid,
  output logic [`NUM_PORTS-1:0]       inReady,
  output flit_t                       outFlit,
  output portId_t                     outSrc,
  output logic                        outValid,
  input  wire logic                   outReady
);

  logic [`NUM_PORTS-1:0]     req;
  logic [`NUM_PORTS-1:0]     pop;
  flit_t [`NUM_PORTS-1:0]    heads;
  flitId_t [`NUM_PORTS-1:0]  headId;
  holdLen_t [`NUM_PORTS-1:0] headLen;
  logic                      grantValid;
  portId_t                   grantPort;
  logic                      take;

  genvar i;
  generate
    for (i = 0; i < `NUM_PORTS; i++)
    begin : genBuffer
      inputBuffer inBuf (
        .clk     (clk),
        .rst     (rst),
        .inFlit  (inFlit[i]),
        .inValid (inValid[i]),
        .inReady (inReady[i]),
        .pop     (pop[i]),
        .req     (req[i]),
        .head    (heads[i])
      );

      assign headId[i]  = heads[i].flitId;
      assign headLen[i] = heads[i].payload[`LEN_W-1:0];  // length field of a header
    end
  endgenerate

  switchArbiter arb (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .headId     (headId),
    .headLen    (headLen),
    .take       (take),
    .grantValid (grantValid),
    .grantPort  (grantPort),
    .pop        (pop)
  );

  outputStage outStage (
    .clk        (clk),
    .rst        (rst),
    .heads      (heads),
    .grantValid (grantValid),
    .grantPort  (grantPort),
    .take       (take),
    .outFlit    (outFlit),
    .outSrc     (outSrc),
    .outValid   (outValid),
    .outReady   (outReady)
  );

endmodule

`default_nettype wire

// ==== src/router_config.svh ====
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// L, N, E, W, S
`define NUM_PORTS 5

// entries per input buffer
`define FIFO_DEPTH 4

`define FLIT_DATA_W 16
`define FLIT_ID_W 3
`define PORT_ID_W 3

// length field sits in the low bits of a header payload
`define LEN_W 12

`endif

// ==== src/switchArbiter.sv ====
`default_nettype none

`include "router_config.svh"

module switchArbiter
  import nocPkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic [`NUM_PORTS-1:0]    req,
  input  wire flitId_t [`NUM_PORTS-1:0] headId,
  input  wire holdLen_t [`NUM_PORTS-1:0] headLen,
  input  wire logic                     take,
  output logic                          grantValid,
  output portId_t                       grantPort,
  output logic [`NUM_PORTS-1:0]         pop
);

  arbState_e state;
  arbState_e nextState;

  logic                  ownerValid;
  portId_t               owner;
  portId_t               scanBase;
  logic [`NUM_PORTS-1:0] expired;
  logic [`NUM_PORTS-1:0] restart;

  assign ownerValid = (state != IDLE);
  assign owner      = ownerValid ? (portId_t'(state) - portId_t'(GRANT_L)) : '0;

  // owner keeps the link only while it has flits and time left
  assign grantValid = ownerValid && req[owner] && !expired[owner];
  assign grantPort  = owner;

  assign pop = (take && grantValid) ? (`NUM_PORTS'(1) << owner) : '0;

  // from idle the scan starts after S, so L comes first
  assign scanBase = ownerValid ? owner : portId_t'(`NUM_PORTS - 1);

  always_comb
  begin
    int cand;
    cand      = 0;
    nextState = state;
    if (!grantValid)
    begin
      nextState = IDLE;
      // walk backwards so the nearest requester after the base wins
      for (int i = `NUM_PORTS; i >= 1; i--)
      begin
        cand = (int'(scanBase) + i) % `NUM_PORTS;
        if (req[cand])
          nextState = arbState_e'(cand + 1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= nextState;
  end

  genvar p;
  generate
    for (p = 0; p < `NUM_PORTS; p++)
    begin : genTimer
      // also fires when an expired owner wins the rotation again
      assign restart[p] = !grantValid && (nextState == arbState_e'(p + 1));

      holdTimer holdCnt (
        .clk     (clk),
        .rst     (rst),
        .load    (pop[p] && (headId[p] == FLIT_HEAD)),
        .loadLen (headLen[p]),
        .run     (pop[p]),
        .restart (restart[p]),
        .expired (expired[p])
      );
    end
  endgenerate

endmodule

`default_nettype wire

// ==== test/routerPortTable.svh ====
`ifndef ROUTER_PORT_TABLE_SVH
`define ROUTER_PORT_TABLE_SVH

// one packet per row, delay counts clocks after the previous row
typedef struct packed {
  portId_t    port;
  holdLen_t   len;     // length field of the header
  logic [7:0] nFlits;  // header, bodies and tail
  logic [7:0] delay;
  logic       bp;      // random gaps in outReady
} pktRow_t;

localparam int NUM_ROWS = 15;

localparam pktRow_t PKT_TABLE [NUM_ROWS] = '{
  // all five at once, two rounds of the rotation
  '{PORT_L, 12'd2, 8'd3, 8'd0, 1'b0},
  '{PORT_N, 12'd2, 8'd3, 8'd0, 1'b0},
  '{PORT_E, 12'd2, 8'd3, 8'd0, 1'b0},
  '{PORT_W, 12'd2, 8'd3, 8'd0, 1'b0},
  '{PORT_S, 12'd2, 8'd3, 8'd0, 1'b0},
  // long limit against limit 1 and limit 0
  '{PORT_L, 12'd8, 8'd6, 8'd40, 1'b0},
  '{PORT_N, 12'd1, 8'd3, 8'd0, 1'b0},
  '{PORT_S, 12'd0, 8'd2, 8'd0, 1'b0},
  // packets longer than the buffer
  '{PORT_E, 12'd3, 8'd9, 8'd40, 1'b0},
  '{PORT_W, 12'd2, 8'd5, 8'd0, 1'b0},
  // link stalls
  '{PORT_L, 12'd4, 8'd7, 8'd40, 1'b1},
  '{PORT_N, 12'd2, 8'd6, 8'd0, 1'b1},
  '{PORT_E, 12'd5, 8'd4, 8'd0, 1'b1},
  '{PORT_S, 12'd3, 8'd5, 8'd0, 1'b1},
  '{PORT_W, 12'd6, 8'd3, 8'd60, 1'b0}
};

`endif

// ==== test/routerPortTb.sv ====
`default_nettype none

`include "router_config.svh"

module routerPortTb
  import nocPkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  `include "routerPortTable.svh"

  logic                   clk;
  logic                   rst;
  flit_t [`NUM_PORTS-1:0] inFlit;
  logic [`NUM_PORTS-1:0]  inValid;
  logic [`NUM_PORTS-1:0]  inReady;
  flit_t                  outFlit;
  portId_t                outSrc;
  logic                   outValid;
  logic                   outReady;

  flit_t   sendQ [`NUM_PORTS][$];
  flit_t   expQ [`NUM_PORTS][$];
  portId_t runOrder [$];
  logic [`NUM_PORTS-1:0] sent;
  int      seqNum [`NUM_PORTS];
  int      portLimit [`NUM_PORTS];
  int      valueErrors;
  int      otherErrors;
  int      departed;
  int      totalFlits;
  logic    bpMode;
  logic    runValid;
  portId_t runSrc;
  int      runLen;
  int      allowed;
  logic    stallPrev;
  flit_t   heldFlit;
  portId_t heldSrc;

  routerPort uut (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outFlit  (outFlit),
    .outSrc   (outSrc),
    .outValid (outValid),
    .outReady (outReady)
  );

  always #20 clk = !clk;

  task automatic checkFlit(input string name, input flit_t exp, input flit_t act);
    if (exp !== act)
    begin
      valueErrors++;
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic checkPort(input string name, input portId_t exp, input portId_t act);
    if (exp !== act)
    begin
      valueErrors++;
      $display("error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic checkCount(input string name, input holdLen_t exp, input holdLen_t act);
    if (exp !== act)
    begin
      valueErrors++;
      $display("error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      valueErrors++;
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  function automatic int countFlits();
    int n;
    n = 0;
    for (int r = 0; r < NUM_ROWS; r++)
      n += int'(PKT_TABLE[r].nFlits);
    return n;
  endfunction

  // header carries the length, the others a per-port sequence number
  task automatic queuePacket(input pktRow_t row);
    flit_t f;
    int    p;
    p = int'(row.port);
    for (int i = 0; i < int'(row.nFlits); i++)
    begin
      if (i == 0)
      begin
        f.flitId  = FLIT_HEAD;
        f.payload = {4'(p), row.len};
      end
      else
      begin
        f.flitId  = (i == int'(row.nFlits) - 1) ? FLIT_TAIL : FLIT_BODY;
        f.payload = {4'(p), 12'(seqNum[p])};
      end
      seqNum[p]++;
      sendQ[p].push_back(f);
      expQ[p].push_back(f);
    end
    bpMode = row.bp;
  endtask

  // inReady seen here is the value the next rising edge samples
  always @(negedge clk)
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (sent[p])
        void'(sendQ[p].pop_front());
      if (!rst && sendQ[p].size() != 0)
      begin
        inFlit[p]  = sendQ[p][0];
        inValid[p] = 1'b1;
        sent[p]    = inReady[p];
      end
      else
      begin
        inValid[p] = 1'b0;
        sent[p]    = 1'b0;
      end
    end
    outReady = bpMode ? ($urandom % 3 != 0) : 1'b1;
  end

  always @(posedge clk)
  begin
    portId_t p;
    if (!rst)
    begin
      if (stallPrev)
      begin
        checkFlit("outFlit", heldFlit, outFlit);
        checkPort("outSrc", heldSrc, outSrc);
      end
      if (!outValid)
        runValid = 1'b0;  // a visible bubble ends the grant
      if (outValid && outReady)
      begin
        p = outSrc;
        departed++;
        if (expQ[p].size() == 0)
        begin
          otherErrors++;
          $display("flit from port %0d left the router but none was expected", p);
        end
        else
          checkFlit("outFlit", expQ[p].pop_front(), outFlit);
        if (!runValid || runSrc != p)
        begin
          runValid = 1'b1;
          runSrc   = p;
          runLen   = 1;
          allowed  = portLimit[p];
          runOrder.push_back(p);
        end
        else
          runLen++;
        if (outFlit.flitId == FLIT_HEAD)
        begin
          portLimit[p] = (outFlit.payload[`LEN_W-1:0] == '0) ? 1 :
                         int'(outFlit.payload[`LEN_W-1:0]);
          allowed = (runLen > portLimit[p]) ? runLen : portLimit[p];
        end
        if (runValid && runLen > allowed)
          checkCount("runLength", holdLen_t'(allowed), holdLen_t'(runLen));
      end
      stallPrev = outValid && !outReady;
      heldFlit  = outFlit;
      heldSrc   = outSrc;
    end
  end

  initial
  begin
    repeat (countFlits() * 8 + 200) @(posedge clk);
    $display("watchdog expired: only %0d of %0d flits left the router", departed, totalFlits);
    $display("Testbench failed");
    $finish;
  end

  initial
  begin
    void'($urandom(26943));
    clk = 1'b0;
    rst = 1'b1;
    inFlit = '0;
    inValid = '0;
    outReady = 1'b1;
    sent = '0;
    bpMode = 1'b0;
    runValid = 1'b0;
    runSrc = '0;
    runLen = 0;
    allowed = 1;
    stallPrev = 1'b0;
    heldFlit = '0;
    heldSrc = '0;
    valueErrors = 0;
    otherErrors = 0;
    departed = 0;
    totalFlits = countFlits();
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      seqNum[p] = 0;
      portLimit[p] = 1;  // reset limit 0 counts as 1
    end
    repeat (4)
    begin
      @(negedge clk);
      checkBit("outValid", 1'b0, outValid);
    end
    rst = 1'b0;
    @(negedge clk);
    checkBit("outValid", 1'b0, outValid);
    for (int p = 0; p < `NUM_PORTS; p++)
      checkBit($sformatf("inReady[%0d]", p), 1'b1, inReady[p]);

    @(posedge clk);
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      repeat (int'(PKT_TABLE[r].delay)) @(posedge clk);
      queuePacket(PKT_TABLE[r]);
    end
    while (departed < totalFlits)
      @(posedge clk);
    repeat (5) @(posedge clk);

    for (int p = 0; p < `NUM_PORTS; p++)
      checkCount($sformatf("flits missing on port %0d", p), '0, holdLen_t'(expQ[p].size()));
    // two full rounds from idle, L first
    if (runOrder.size() < 10)
    begin
      otherErrors++;
      $display("fewer than ten bursts seen in the first group");
    end
    else
      for (int k = 0; k < 10; k++)
        checkPort($sformatf("burst %0d source", k), portId_t'(k % 5), runOrder[k]);

    $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
